// File: include/cache_geom.svh
// Direct-mapped geometry with one 64-bit word per line
// All sizes must stay powers of two

`ifndef CACHE_GEOM_SVH
`define CACHE_GEOM_SVH

// Bytes per block, equal to one data word
`define CACHE_BLOCK_BYTES 8
// Number of lines in the array
`define CACHE_LINES 32
// Byte address width on both buses
`define CACHE_ADDR_W 16

`endif

// File: verilog/mem_bus_pkg.sv
// Processor and memory bus types
// A memory tag of zero always means the command was refused

package mem_bus_pkg;

`include "cache_geom.svh"

    // Bus command, shared by processor and memory side
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_cmd_e;

    // Memory transaction tag width
    localparam int MEM_TAG_W = 4;

    // Processor request id width
    localparam int REQ_ID_W = 4;

    // One data word
    typedef logic [63:0] word_t;

    // Raw byte address as memory sees it
    typedef logic [`CACHE_ADDR_W-1:0] mem_addr_t;

endpackage

// File: verilog/cache_pkg.sv
// Cache address decoding and MSHR states
// Field widths follow the shared geometry header

package cache_pkg;

`include "cache_geom.svh"

    // ------------------------------
    // Address fields
    // ------------------------------
    localparam int LINE_OFF_W = $clog2(`CACHE_BLOCK_BYTES);
    localparam int LINE_IDX_W = $clog2(`CACHE_LINES);
    localparam int LINE_TAG_W = `CACHE_ADDR_W - LINE_IDX_W - LINE_OFF_W;

    // Tag, index, offset from msb down
    typedef struct packed {
        logic [LINE_TAG_W-1:0] tag;
        logic [LINE_IDX_W-1:0] idx;
        logic [LINE_OFF_W-1:0] off;
    } cache_addr_fields_t;

    // Same word seen as raw address or as fields
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        cache_addr_fields_t       f;
    } cache_addr_u;

    // ------------------------------
    // MSHR entry states
    // ------------------------------
    typedef enum logic [2:0] {
        MSHR_IDLE      = 3'd0,
        MSHR_WRITEBACK = 3'd1,
        MSHR_FETCH     = 3'd2,
        MSHR_WAIT      = 3'd3,
        MSHR_FILL      = 3'd4
    } mshr_state_e;

endpackage

// File: verilog/cache_ifs.sv
// Internal buses between request, lookup and MSHR stages
// No clock inside; every producer registers or decodes on its own
`timescale 1ns/1ps

// Request sitting in the request stage
interface cache_req_if
    import mem_bus_pkg::*, cache_pkg::*;
();
    logic                valid;
    bus_cmd_e            cmd;
    cache_addr_u         addr;
    word_t               data;
    logic [REQ_ID_W-1:0] id;

    modport stage   (output valid, cmd, addr, data, id);
    modport lookup  (input valid, cmd, addr, data, id);
    // MSHR only needs the index for conflicts
    modport monitor (input valid, addr);
endinterface

// One-cycle miss pulse with the victim line
interface miss_if
    import mem_bus_pkg::*, cache_pkg::*;
();
    logic                valid;
    bus_cmd_e            cmd;
    cache_addr_u         addr;
    word_t               data;
    logic [REQ_ID_W-1:0] id;
    logic                victim_dirty;
    mem_addr_t           victim_addr;
    word_t               victim_data;

    modport src (output valid, cmd, addr, data, id, victim_dirty, victim_addr, victim_data);
    modport dst (input valid, cmd, addr, data, id, victim_dirty, victim_addr, victim_data);
endinterface

// Line write from a finished miss
interface fill_if
    import mem_bus_pkg::*, cache_pkg::*;
();
    logic                  valid;
    logic [LINE_IDX_W-1:0] idx;
    logic [LINE_TAG_W-1:0] tag;
    word_t                 data;
    logic                  dirty;

    modport src (output valid, idx, tag, data, dirty);
    modport dst (input valid, idx, tag, data, dirty);
endinterface

// File: verilog/cache_req_stage.sv
// Processor must hold its inputs while stall_i is high
`timescale 1ns/1ps

module cache_req_stage
    import mem_bus_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  bus_cmd_e            proc_cmd_i,
    input  mem_addr_t           proc_addr_i,
    input  word_t               proc_data_i,
    input  logic [REQ_ID_W-1:0] proc_id_i,
    input  logic                stall_i,
    cache_req_if.stage          req
);

    // Valid only; an empty slot never stalls
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req.valid <= 1'b0;
        end else if (!stall_i) begin
            // Old request used this cycle, replace or drop it
            req.valid <= (proc_cmd_i != BUS_NONE);
        end
    end

    // Payload follows valid, held on stall
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            req.cmd      <= proc_cmd_i;
            req.addr.raw <= proc_addr_i;
            req.data     <= proc_data_i;
            req.id       <= proc_id_i;
        end
    end

endmodule

// File: verilog/cache_line_array.sv
// Direct-mapped tag and data array, one word per line
// Fill and lookup never share a cycle; the MSHR stall keeps them apart
`timescale 1ns/1ps

module cache_line_array
    import mem_bus_pkg::*, cache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    cache_req_if.lookup         req,
    input  logic                stall_i,
    miss_if.src                 miss,
    fill_if.dst                 fill,
    output logic                hit_valid_o,
    output word_t               hit_data_o,
    output logic [REQ_ID_W-1:0] hit_id_o
);

    localparam int LINES = 1 << LINE_IDX_W;

    // ------------------------------
    // Storage
    // ------------------------------
    logic [LINES-1:0]      valid_q;
    logic [LINES-1:0]      dirty_q;
    logic [LINE_TAG_W-1:0] tag_mem [LINES];
    word_t                 data_mem [LINES];

    logic [LINE_IDX_W-1:0] idx;
    logic                  hit;
    logic                  go;

    assign idx = req.addr.f.idx;
    assign hit = valid_q[idx] && (tag_mem[idx] == req.addr.f.tag);
    // Lookup acts only on an unstalled request
    assign go  = req.valid && !stall_i;

    // ------------------------------
    // Miss pulse and victim capture
    // ------------------------------
    always_comb begin
        cache_addr_u victim;
        victim.f.tag = tag_mem[idx];
        victim.f.idx = idx;
        victim.f.off = '0;

        miss.valid        = go && !hit;
        miss.cmd          = req.cmd;
        miss.addr         = req.addr;
        miss.data         = req.data;
        miss.id           = req.id;
        // Invalid line never needs a writeback
        miss.victim_dirty = valid_q[idx] && dirty_q[idx];
        miss.victim_addr  = victim.raw;
        miss.victim_data  = data_mem[idx];
    end

    // ------------------------------
    // Line state and hit completion
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q     <= '0;
            dirty_q     <= '0;
            hit_valid_o <= 1'b0;
        end else begin
            hit_valid_o <= go && hit;
            if (fill.valid) begin
                valid_q[fill.idx] <= 1'b1;
                dirty_q[fill.idx] <= fill.dirty;
            end
            // Victim now lives in the MSHR
            if (go && !hit) begin
                valid_q[idx] <= 1'b0;
            end
            if (go && hit && (req.cmd == BUS_STORE)) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    // Tag and data writes, hit payload
    always_ff @(posedge clk_i) begin
        if (fill.valid) begin
            tag_mem[fill.idx]  <= fill.tag;
            data_mem[fill.idx] <= fill.data;
        end
        if (go && hit && (req.cmd == BUS_STORE)) begin
            data_mem[idx] <= req.data;
        end
        // Stores complete with zero data
        hit_data_o <= (req.cmd == BUS_LOAD) ? data_mem[idx] : '0;
        hit_id_o   <= req.id;
    end

endmodule

// File: verilog/mshr_file.sv
// Miss status registers; secondary misses to an open index stall
// Store misses fetch the old word too, then overwrite it on fill
`timescale 1ns/1ps

module mshr_file
    import mem_bus_pkg::*, cache_pkg::*;
#(
    parameter int MSHR_NUM = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    cache_req_if.monitor                  req,
    miss_if.dst                           miss,
    fill_if.src                           fill,
    output logic                          stall_o,
    output logic     [MSHR_NUM-1:0]       issue_req_o,
    output bus_cmd_e [MSHR_NUM-1:0]       issue_cmd_o,
    output mem_addr_t [MSHR_NUM-1:0]      issue_addr_o,
    output word_t    [MSHR_NUM-1:0]       issue_data_o,
    input  logic     [MSHR_NUM-1:0]       grant_i,
    input  logic     [MEM_TAG_W-1:0]      mem_response_i,
    input  logic     [MEM_TAG_W-1:0]      mem_tag_i,
    input  word_t                         mem_data_i,
    output logic                          miss_valid_o,
    output word_t                         miss_data_o,
    output logic     [REQ_ID_W-1:0]       miss_id_o
);

    localparam int IDX_W = (MSHR_NUM > 1) ? $clog2(MSHR_NUM) : 1;

    // ------------------------------
    // Entry storage
    // ------------------------------
    mshr_state_e         state_q       [MSHR_NUM];
    bus_cmd_e            cmd_q         [MSHR_NUM];
    cache_addr_u         addr_q        [MSHR_NUM];
    // Store data, or load data once returned
    word_t               data_q        [MSHR_NUM];
    logic [REQ_ID_W-1:0] id_q          [MSHR_NUM];
    mem_addr_t           victim_addr_q [MSHR_NUM];
    word_t               victim_data_q [MSHR_NUM];
    logic [MEM_TAG_W-1:0] tag_q        [MSHR_NUM];

    logic [MSHR_NUM-1:0] accept;
    logic                free_any;
    logic [IDX_W-1:0]    alloc_idx;
    logic                idx_match;
    logic                fill_next;
    logic                fill_act;
    logic [IDX_W-1:0]    fill_sel;

    // Command taken only with a nonzero tag
    assign accept = (mem_response_i != '0) ? grant_i : '0;

    // ------------------------------
    // Free entry, conflicts, fill
    // ------------------------------
    always_comb begin
        free_any  = 1'b0;
        alloc_idx = '0;
        idx_match = 1'b0;
        fill_next = 1'b0;
        fill_act  = 1'b0;
        fill_sel  = '0;
        // Downward scan leaves the lowest free entry
        for (int i = MSHR_NUM - 1; i >= 0; i--) begin
            if (state_q[i] == MSHR_IDLE) begin
                free_any  = 1'b1;
                alloc_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < MSHR_NUM; i++) begin
            if ((state_q[i] != MSHR_IDLE) && (addr_q[i].f.idx == req.addr.f.idx)) begin
                idx_match = 1'b1;
            end
            // Stored tag is never zero
            if ((state_q[i] == MSHR_WAIT) && (mem_tag_i == tag_q[i])) begin
                fill_next = 1'b1;
            end
            // One tag per cycle, so at most one entry fills
            if (state_q[i] == MSHR_FILL) begin
                fill_act = 1'b1;
                fill_sel = IDX_W'(i);
            end
        end
    end

    // Fill next cycle also blocks, else a hit would land on the miss completion
    assign stall_o = req.valid && (!free_any || idx_match || fill_act || fill_next);

    // ------------------------------
    // Entry FSMs
    // ------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < MSHR_NUM; i++) begin
            if (rst_i) begin
                state_q[i] <= MSHR_IDLE;
            end else begin
                case (state_q[i])
                    MSHR_IDLE: begin
                        if (miss.valid && (alloc_idx == IDX_W'(i))) begin
                            state_q[i] <= miss.victim_dirty ? MSHR_WRITEBACK : MSHR_FETCH;
                        end
                    end
                    MSHR_WRITEBACK: if (accept[i]) state_q[i] <= MSHR_FETCH;
                    MSHR_FETCH:     if (accept[i]) state_q[i] <= MSHR_WAIT;
                    MSHR_WAIT:      if (mem_tag_i == tag_q[i]) state_q[i] <= MSHR_FILL;
                    // Fill lasts one cycle
                    default:        state_q[i] <= MSHR_IDLE;
                endcase
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < MSHR_NUM; i++) begin
            if ((state_q[i] == MSHR_IDLE) && miss.valid && (alloc_idx == IDX_W'(i))) begin
                cmd_q[i]         <= miss.cmd;
                addr_q[i]        <= miss.addr;
                // Block aligned for the fetch
                addr_q[i].f.off  <= '0;
                data_q[i]        <= miss.data;
                id_q[i]          <= miss.id;
                victim_addr_q[i] <= miss.victim_addr;
                victim_data_q[i] <= miss.victim_data;
            end
            if ((state_q[i] == MSHR_FETCH) && accept[i]) begin
                tag_q[i] <= mem_response_i;
            end
            // Store keeps its own word
            if ((state_q[i] == MSHR_WAIT) && (mem_tag_i == tag_q[i]) && (cmd_q[i] == BUS_LOAD)) begin
                data_q[i] <= mem_data_i;
            end
        end
    end

    // ------------------------------
    // Memory requests per entry
    // ------------------------------
    always_comb begin
        for (int i = 0; i < MSHR_NUM; i++) begin
            issue_req_o[i]  = (state_q[i] == MSHR_WRITEBACK) || (state_q[i] == MSHR_FETCH);
            issue_cmd_o[i]  = (state_q[i] == MSHR_WRITEBACK) ? BUS_STORE : BUS_LOAD;
            issue_addr_o[i] = (state_q[i] == MSHR_WRITEBACK) ? victim_addr_q[i] : addr_q[i].raw;
            issue_data_o[i] = victim_data_q[i];
        end
    end

    // Line write and completion from the filling entry
    always_comb begin
        fill.valid = fill_act;
        fill.idx   = addr_q[fill_sel].f.idx;
        fill.tag   = addr_q[fill_sel].f.tag;
        fill.data  = data_q[fill_sel];
        // Store miss leaves the line dirty
        fill.dirty = (cmd_q[fill_sel] == BUS_STORE);
    end

    assign miss_valid_o = fill_act;
    assign miss_data_o  = (cmd_q[fill_sel] == BUS_LOAD) ? data_q[fill_sel] : '0;
    assign miss_id_o    = id_q[fill_sel];

endmodule

// File: verilog/mem_issue_arbiter.sv
// Round-robin over MSHR entries, pointer moves only on acceptance
// MSHR_NUM must be a power of two
`timescale 1ns/1ps

module mem_issue_arbiter
    import mem_bus_pkg::*;
#(
    parameter int MSHR_NUM = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic      [MSHR_NUM-1:0]  issue_req_i,
    input  bus_cmd_e  [MSHR_NUM-1:0]  issue_cmd_i,
    input  mem_addr_t [MSHR_NUM-1:0]  issue_addr_i,
    input  word_t     [MSHR_NUM-1:0]  issue_data_i,
    output logic      [MSHR_NUM-1:0]  grant_o,
    output bus_cmd_e                  mem_cmd_o,
    output mem_addr_t                 mem_addr_o,
    output word_t                     mem_data_o,
    input  logic      [MEM_TAG_W-1:0] mem_response_i
);

    localparam int PTR_W = (MSHR_NUM > 1) ? $clog2(MSHR_NUM) : 1;

    logic [PTR_W-1:0] last_q;
    logic [PTR_W-1:0] sel;
    logic             found;

    // Search starts just after the last accepted entry
    always_comb begin
        int j;
        found = 1'b0;
        sel   = last_q;
        for (int k = 1; k <= MSHR_NUM; k++) begin
            j = (int'(last_q) + k) % MSHR_NUM;
            if (!found && issue_req_i[j]) begin
                found = 1'b1;
                sel   = PTR_W'(j);
            end
        end
    end

    assign grant_o    = found ? (MSHR_NUM'(1) << sel) : '0;
    assign mem_cmd_o  = found ? issue_cmd_i[sel] : BUS_NONE;
    assign mem_addr_o = issue_addr_i[sel];
    assign mem_data_o = issue_data_i[sel];

    // Refused command is offered again next cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Entry 0 goes first after reset
            last_q <= PTR_W'(MSHR_NUM - 1);
        end else if (found && (mem_response_i != '0)) begin
            last_q <= sel;
        end
    end

endmodule

// File: verilog/nb_cache_top.sv
// Non-blocking write-back cache, hits complete two edges after acceptance
// Misses complete out of order; match completions by proc_id_o
`timescale 1ns/1ps

module nb_cache_top
    import mem_bus_pkg::*;
#(
    parameter int MSHR_NUM = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // Processor side
    input  bus_cmd_e             proc_cmd_i,
    input  mem_addr_t            proc_addr_i,
    input  word_t                proc_data_i,
    input  logic [REQ_ID_W-1:0]  proc_id_i,
    output logic                 proc_stall_o,
    output logic                 proc_valid_o,
    output word_t                proc_data_o,
    output logic [REQ_ID_W-1:0]  proc_id_o,
    // Memory side
    output bus_cmd_e             mem_cmd_o,
    output mem_addr_t            mem_addr_o,
    output word_t                mem_data_o,
    input  logic [MEM_TAG_W-1:0] mem_response_i,
    input  logic [MEM_TAG_W-1:0] mem_tag_i,
    input  word_t                mem_data_i
);

    cache_req_if req_bus ();
    miss_if      miss_bus ();
    fill_if      fill_bus ();

    logic                      stall;
    logic                      hit_valid;
    word_t                     hit_data;
    logic [REQ_ID_W-1:0]       hit_id;
    logic                      miss_valid;
    word_t                     miss_data;
    logic [REQ_ID_W-1:0]       miss_id;
    logic      [MSHR_NUM-1:0]  issue_req;
    bus_cmd_e  [MSHR_NUM-1:0]  issue_cmd;
    mem_addr_t [MSHR_NUM-1:0]  issue_addr;
    word_t     [MSHR_NUM-1:0]  issue_data;
    logic      [MSHR_NUM-1:0]  grant;

    cache_req_stage u_req (
        .clk_i, .rst_i, .proc_cmd_i, .proc_addr_i, .proc_data_i, .proc_id_i,
        .stall_i (stall),
        .req     (req_bus)
    );

    cache_line_array u_lines (
        .clk_i, .rst_i,
        .req         (req_bus),
        .stall_i     (stall),
        .miss        (miss_bus),
        .fill        (fill_bus),
        .hit_valid_o (hit_valid),
        .hit_data_o  (hit_data),
        .hit_id_o    (hit_id)
    );

    mshr_file #(.MSHR_NUM(MSHR_NUM)) u_mshr (
        .clk_i, .rst_i, .mem_response_i, .mem_tag_i, .mem_data_i,
        .req          (req_bus),
        .miss         (miss_bus),
        .fill         (fill_bus),
        .stall_o      (stall),
        .issue_req_o  (issue_req),
        .issue_cmd_o  (issue_cmd),
        .issue_addr_o (issue_addr),
        .issue_data_o (issue_data),
        .grant_i      (grant),
        .miss_valid_o (miss_valid),
        .miss_data_o  (miss_data),
        .miss_id_o    (miss_id)
    );

    mem_issue_arbiter #(.MSHR_NUM(MSHR_NUM)) u_arb (
        .clk_i, .rst_i, .mem_cmd_o, .mem_addr_o, .mem_data_o, .mem_response_i,
        .issue_req_i  (issue_req),
        .issue_cmd_i  (issue_cmd),
        .issue_addr_i (issue_addr),
        .issue_data_i (issue_data),
        .grant_o      (grant)
    );

    // Hit and miss completions never overlap
    assign proc_stall_o = stall;
    assign proc_valid_o = hit_valid || miss_valid;
    assign proc_data_o  = miss_valid ? miss_data : hit_data;
    assign proc_id_o    = miss_valid ? miss_id : hit_id;

endmodule

// File: dv/tb_clk_gen.sv
// Free-running clock, reset released by a nonblocking write on a rising edge
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset high for the first edges only
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: dv/tb_mem_model.sv
// Tagged memory, fixed load latency, refuses about one command in four
// Word at byte address A starts as A times 64'h0101_0101_0101_0101
`timescale 1ns/1ps

module tb_mem_model
    import mem_bus_pkg::*;
#(
    parameter int LATENCY = 10
) (
    input  logic                 clk_i,
    input  bus_cmd_e             mem_cmd_i,
    input  mem_addr_t            mem_addr_i,
    input  word_t                mem_data_i,
    output logic [MEM_TAG_W-1:0] mem_response_o,
    output logic [MEM_TAG_W-1:0] mem_tag_o,
    output word_t                mem_data_o
);

    localparam int WORDS = 1 << 13;

    word_t                mem [WORDS];
    integer               seed;
    logic                 refuse_q;
    logic [MEM_TAG_W-1:0] next_tag_q;
    // Return pipeline, slot 0 leaves next
    logic [MEM_TAG_W-1:0] pipe_tag  [LATENCY];
    word_t                pipe_data [LATENCY];

    initial begin
        seed       = 32'hee03_d3de;
        refuse_q   = 1'b0;
        next_tag_q = 1;
        mem_tag_o  = '0;
        mem_data_o = '0;
        for (int a = 0; a < WORDS; a++) begin
            mem[a] = (64'(a) * 64'd8) * 64'h0101_0101_0101_0101;
        end
        for (int k = 0; k < LATENCY; k++) begin
            pipe_tag[k]  = '0;
            pipe_data[k] = '0;
        end
    end

    // Same-cycle answer, zero means refused
    assign mem_response_o = ((mem_cmd_i != BUS_NONE) && !refuse_q) ? next_tag_q : '0;

    always @(posedge clk_i) begin
        refuse_q   <= (($random(seed) & 32'd3) == 0);
        mem_tag_o  <= pipe_tag[0];
        mem_data_o <= pipe_data[0];
        for (int k = 0; k < LATENCY - 1; k++) begin
            pipe_tag[k]  <= pipe_tag[k + 1];
            pipe_data[k] <= pipe_data[k + 1];
        end
        pipe_tag[LATENCY - 1] <= '0;
        if (mem_response_o != '0) begin
            // Tags 1 to 15 in turn
            next_tag_q <= (next_tag_q == 4'd15) ? 4'd1 : next_tag_q + 4'd1;
            if (mem_cmd_i == BUS_STORE) begin
                mem[mem_addr_i >> 3] <= mem_data_i;
            end else begin
                pipe_tag[LATENCY - 1]  <= mem_response_o;
                pipe_data[LATENCY - 1] <= mem[mem_addr_i >> 3];
            end
        end
    end

endmodule

// File: dv/tb_nb_cache.sv
// Table-driven test, ids are the table index modulo 16
// An id is reused only after its previous request has completed
`timescale 1ns/1ps

module tb_nb_cache
    import mem_bus_pkg::*;
();

    localparam int MAX_ENTRIES     = 64;
    localparam int CYCLES_PER_ITEM = 40;

    logic                 clk;
    logic                 rst;
    bus_cmd_e             proc_cmd_i;
    mem_addr_t            proc_addr_i;
    word_t                proc_data_i;
    logic [REQ_ID_W-1:0]  proc_id_i;
    logic                 proc_stall_o;
    logic                 proc_valid_o;
    word_t                proc_data_o;
    logic [REQ_ID_W-1:0]  proc_id_o;
    bus_cmd_e             mem_cmd_o;
    mem_addr_t            mem_addr_o;
    word_t                mem_data_o;
    logic [MEM_TAG_W-1:0] mem_response_i;
    logic [MEM_TAG_W-1:0] mem_tag_i;
    word_t                mem_data_i;

    // Stimulus table
    bus_cmd_e  tab_cmd   [MAX_ENTRIES];
    mem_addr_t tab_addr  [MAX_ENTRIES];
    word_t     tab_data  [MAX_ENTRIES];
    bit        tab_quiet [MAX_ENTRIES];
    bit        tab_hit   [MAX_ENTRIES];
    // Entry must be held in the request stage at least one cycle
    bit        tab_stall [MAX_ENTRIES];
    int        n_entries = 0;

    // Golden memory and per-id bookkeeping
    word_t golden [1 << 13];
    bit    busy [16];
    word_t exp_data [16];
    int    acc_cycle [16];
    bit    hit_chk [16];
    int    open_cnt = 0;
    int    cycle = 0;

    tb_clk_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(2)) u_clk (.clk_o(clk), .rst_o(rst));

    tb_mem_model #(.LATENCY(10)) u_mem (
        .clk_i          (clk),
        .mem_cmd_i      (mem_cmd_o),
        .mem_addr_i     (mem_addr_o),
        .mem_data_i     (mem_data_o),
        .mem_response_o (mem_response_i),
        .mem_tag_o      (mem_tag_i),
        .mem_data_o     (mem_data_i)
    );

    nb_cache_top #(.MSHR_NUM(4)) DUT (
        .clk_i (clk),
        .rst_i (rst),
        .proc_cmd_i, .proc_addr_i, .proc_data_i, .proc_id_i, .proc_stall_o,
        .proc_valid_o, .proc_data_o, .proc_id_o,
        .mem_cmd_o, .mem_addr_o, .mem_data_o, .mem_response_i, .mem_tag_i, .mem_data_i
    );

    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic fail_run(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // ------------------------------
    // Table
    // ------------------------------
    task automatic add_entry(input bus_cmd_e c, input int a, input word_t d,
                             input bit quiet, input bit hit_check);
        tab_cmd[n_entries]   = c;
        tab_addr[n_entries]  = mem_addr_t'(a);
        tab_data[n_entries]  = d;
        tab_quiet[n_entries] = quiet;
        tab_hit[n_entries]   = hit_check;
        tab_stall[n_entries] = 1'b0;
        n_entries++;
    endtask

    // Last entry waits behind an open miss or a full MSHR file
    task automatic expect_stall_on_last();
        tab_stall[n_entries - 1] = 1'b1;
    endtask

    task automatic build_table();
        // Cold misses
        add_entry(BUS_LOAD,  'h0100, '0, 0, 0);
        add_entry(BUS_LOAD,  'h0208, '0, 0, 0);
        add_entry(BUS_LOAD,  'h0310, '0, 0, 0);
        // Hits on an idle cache, two edges
        add_entry(BUS_LOAD,  'h0100, '0, 1, 1);
        add_entry(BUS_LOAD,  'h0208, '0, 1, 1);
        // Store hit, store miss, then loads
        add_entry(BUS_STORE, 'h0310, 64'hdead_beef_0000_0001, 0, 0);
        add_entry(BUS_LOAD,  'h0310, '0, 0, 0);
        add_entry(BUS_STORE, 'h0418, 64'hcafe_f00d_0000_0002, 0, 0);
        add_entry(BUS_LOAD,  'h0418, '0, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_LOAD,  'h0418, '0, 1, 1);
        // Dirty victims must reach memory
        add_entry(BUS_STORE, 'h0520, 64'h1234_5678_9abc_def0, 0, 0);
        add_entry(BUS_LOAD,  'h0620, '0, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_LOAD,  'h0520, '0, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_STORE, 'h0100, 64'h0f0f_0f0f_a5a5_a5a5, 0, 0);
        add_entry(BUS_LOAD,  'h0900, '0, 0, 0);
        add_entry(BUS_LOAD,  'h0100, '0, 0, 0);
        expect_stall_on_last();
        // Several misses open at once
        add_entry(BUS_LOAD,  'h1028, '0, 1, 0);
        add_entry(BUS_LOAD,  'h1130, '0, 0, 0);
        add_entry(BUS_LOAD,  'h1238, '0, 0, 0);
        add_entry(BUS_LOAD,  'h1340, '0, 0, 0);
        add_entry(BUS_STORE, 'h1448, 64'h5555_0000_0000_0005, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_STORE, 'h1550, 64'h6666_0000_0000_0006, 0, 0);
        add_entry(BUS_STORE, 'h1658, 64'h7777_0000_0000_0007, 0, 0);
        add_entry(BUS_STORE, 'h1760, 64'h8888_0000_0000_0008, 0, 0);
        add_entry(BUS_LOAD,  'h1448, '0, 0, 0);
        add_entry(BUS_LOAD,  'h1550, '0, 0, 0);
        add_entry(BUS_LOAD,  'h1658, '0, 0, 0);
        add_entry(BUS_LOAD,  'h1760, '0, 0, 0);
        // Same index as an open miss
        add_entry(BUS_LOAD,  'h2068, '0, 0, 0);
        add_entry(BUS_LOAD,  'h2168, '0, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_STORE, 'h2268, 64'h9999_0000_0000_0009, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_LOAD,  'h2068, '0, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_STORE, 'h2370, 64'haaaa_0000_0000_000a, 0, 0);
        add_entry(BUS_LOAD,  'h2470, '0, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_LOAD,  'h2370, '0, 0, 0);
        expect_stall_on_last();
        add_entry(BUS_LOAD,  'h2370, '0, 1, 1);
    endtask

    // Drive one entry and book it once the DUT takes it
    task automatic apply_entry(input int i);
        logic [REQ_ID_W-1:0] id;
        int                  w;
        bit                  saw_stall;
        id        = REQ_ID_W'(i);
        w         = int'(tab_addr[i] >> 3);
        saw_stall = 1'b0;
        // Any stall seen before booking belongs to the previous entry
        if (tab_quiet[i]) begin
            while (open_cnt != 0) begin
                @(negedge clk);
                saw_stall = saw_stall || proc_stall_o;
            end
        end
        while (busy[id]) begin
            @(negedge clk);
            saw_stall = saw_stall || proc_stall_o;
        end
        @(posedge clk);
        proc_cmd_i  <= tab_cmd[i];
        proc_addr_i <= tab_addr[i];
        proc_data_i <= tab_data[i];
        proc_id_i   <= id;
        @(negedge clk);
        saw_stall = saw_stall || proc_stall_o;
        while (proc_stall_o) @(negedge clk);
        if ((i > 0) && tab_stall[i - 1]) begin
            check_value("proc_stall_o", 64'(saw_stall), 64'd1);
        end
        // Taken at the coming edge, in program order
        busy[id]      = 1'b1;
        hit_chk[id]   = tab_hit[i];
        acc_cycle[id] = cycle;
        open_cnt++;
        if (tab_cmd[i] == BUS_STORE) begin
            golden[w]    = tab_data[i];
            exp_data[id] = '0;
        end else begin
            exp_data[id] = golden[w];
        end
        @(posedge clk);
        proc_cmd_i <= BUS_NONE;
    endtask

    // ------------------------------
    // Completion monitor
    // ------------------------------
    always @(negedge clk) begin
        if (!rst && proc_valid_o) begin
            if (!busy[proc_id_o]) begin
                fail_run($sformatf("Completion for id %0d which is not outstanding",
                                   proc_id_o));
            end
            check_value("proc_data_o", proc_data_o, exp_data[proc_id_o]);
            if (hit_chk[proc_id_o]) begin
                check_value("hit latency", 64'(cycle - acc_cycle[proc_id_o]), 64'd2);
            end
            busy[proc_id_o] = 1'b0;
            open_cnt--;
        end
    end

    // Watchdog scaled by table length
    initial begin
        wait (n_entries != 0);
        repeat (n_entries * CYCLES_PER_ITEM) @(posedge clk);
        fail_run("Timeout: requests did not all complete in time");
    end

    initial begin
        proc_cmd_i  = BUS_NONE;
        proc_addr_i = '0;
        proc_data_i = '0;
        proc_id_i   = '0;
        for (int a = 0; a < (1 << 13); a++) begin
            golden[a] = (64'(a) * 64'd8) * 64'h0101_0101_0101_0101;
        end
        for (int k = 0; k < 16; k++) begin
            busy[k]    = 1'b0;
            hit_chk[k] = 1'b0;
        end
        build_table();
        @(negedge clk);
        while (rst) @(negedge clk);
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        while (open_cnt != 0) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
verilog/mem_bus_pkg.sv
verilog/cache_pkg.sv
verilog/cache_ifs.sv
verilog/cache_req_stage.sv
verilog/cache_line_array.sv
verilog/mshr_file.sv
verilog/mem_issue_arbiter.sv
verilog/nb_cache_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_model.sv
dv/tb_nb_cache.sv
